// File: vlog.f
core_pkg.sv
uop_decoder.sv
stage_reg.sv
reg_file.sv
alu_execute.sv
decode_exec_top.sv
tb_decode_exec.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_decode_exec
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb_decode_exec.sv
module tb_decode_exec import core_pkg::*; ();

    // test lengths in cycles with reset first.
    localparam int RUN_CYCLES = 4 + 7 + 7 + 33 + 5 + 9 + 12;

    logic              clk_i;
    logic              rstn_i;
    logic              instr_valid_i;
    logic [31:0]       instr_i;
    logic [XLEN-1:0]   pc_i;
    logic              flush_i;
    logic              illegal_o;
    logic              wb_valid_o;
    logic [REG_AW-1:0] wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;
    logic [TAG_W-1:0]  wb_tag_o;

    // reference model state.
    logic [31:0] mregs [32];
    logic [3:0]  m_tag;
    logic        p_v, p_flush, d_v, d_ill, w_v;
    logic [31:0] p_instr, p_pc, d_instr, d_pc, w_data;
    logic [3:0]  d_tag, w_tag;
    logic [4:0]  w_rd;

    logic [31:0] seed;
    logic [31:0] pc_ctr;
    string       cur_test;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;

    decode_exec_top dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .flush_i       (flush_i),
        .illegal_o     (illegal_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_tag_o      (wb_tag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // encoders and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_rs(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [4:0] rd);
        return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
            input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [4:0] pick_reg();   // x1..x7.
        logic [31:0] r;
        r = lcg_next() % 32'd7;
        return r[4:0] + 5'd1;
    endfunction

    // 0 executes, 1 recognised only, 2 illegal.
    function automatic int kind_of(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[6:0] == OPC_LUI || w[6:0] == OPC_AUIPC) return 0;
        if (w[6:0] == OPC_JAL) return 1;
        if (w[6:0] == OPC_JALR) return (f3 == 3'b000) ? 1 : 2;
        if (w[6:0] == OPC_BRANCH) return (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b100) ? 1 : 2;
        if (w[6:0] == OPC_LOAD || w[6:0] == OPC_STORE) return (f3 == 3'b010) ? 1 : 2;
        if (w[6:0] == OPC_OP_IMM) return (f3 == 3'b000) ? 0 : 2;
        if (w[6:0] == OPC_OP && f7 == 7'b0100000 && f3 == 3'b000) return 0;
        if (w[6:0] == OPC_OP && f7 == 7'b0000000 && f3 != 3'b001 && f3 != 3'b010
                && f3 != 3'b011 && f3 != 3'b101) return 0;
        return 2;
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        case (w[6:0])
            OPC_LUI:    return {w[31:12], 12'b0};
            OPC_AUIPC:  return pc + {w[31:12], 12'b0};
            OPC_OP_IMM: return a + {{20{w[31]}}, w[31:20]};
            default: begin
                if (w[30]) return a - b;
                case (w[14:12])
                    3'b100:  return a ^ b;
                    3'b110:  return a | b;
                    3'b111:  return a & b;
                    default: return a + b;
                endcase
            end
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // cycle driver and checker
    // ------------------------------------------------------------------------
    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: %s expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic step_cycle(input logic v, input logic [31:0] w, input logic fl);
        int k;
        @(posedge clk_i);
        instr_valid_i <= v;
        instr_i       <= w;
        pc_i          <= pc_ctr;
        flush_i       <= fl;
        // advance the model by the edge just taken.
        w_v = d_v && !p_flush;
        if (w_v) begin
            w_rd   = d_instr[11:7];
            w_data = model_result(d_instr, d_pc);
            w_tag  = d_tag;
            if (w_rd != 5'd0) mregs[w_rd] = w_data;
        end
        if (p_flush) begin
            if (d_v) m_tag = m_tag - 1'b1;   // killed tag is reused.
            d_v   = 1'b0;
            d_ill = 1'b0;
        end else begin
            k       = kind_of(p_instr);
            d_v     = p_v && (k == 0);
            d_ill   = p_v && (k == 2);
            d_instr = p_instr;
            d_pc    = p_pc;
            d_tag   = m_tag;
            if (d_v) m_tag = m_tag + 1'b1;
        end
        p_v     = v;
        p_instr = w;
        p_pc    = pc_ctr;
        p_flush = fl;
        pc_ctr  = pc_ctr + 32'd4;
        @(negedge clk_i);
        compare("illegal_o", 32'(d_ill), 32'(illegal_o));
        compare("wb_valid_o", 32'(w_v), 32'(wb_valid_o));
        if (w_v) begin
            compare("wb_rd_o", 32'(w_rd), 32'(wb_rd_o));
            compare("wb_data_o", w_data, wb_data_o);
            compare("wb_tag_o", 32'(w_tag), 32'(wb_tag_o));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step_cycle(1'b0, 32'h0, 1'b0);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        idle(3);   // drain the pipe.
        if (errors != test_errs) tests_failed++;
        $display("test %s finished with %0d errors", cur_test, errors - test_errs);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        start_test("reset_state");
        idle(3);
        step_cycle(1'b1, enc_rs(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd1, OPC_OP), 1'b0);
        finish_test();
    endtask

    task automatic test_imm_forms();
        start_test("imm_forms");
        step_cycle(1'b1, enc_i(12'h123, 5'd0, 5'd1), 1'b0);
        step_cycle(1'b1, enc_i(12'hffb, 5'd1, 5'd2), 1'b0);   // negative.
        step_cycle(1'b1, enc_u(OPC_LUI, 20'habcde, 5'd3), 1'b0);
        step_cycle(1'b1, enc_u(OPC_AUIPC, 20'h00012, 5'd4), 1'b0);
        finish_test();
    endtask

    task automatic test_reg_ops();
        logic [31:0] r;
        logic [31:0] sel;
        logic [4:0]  rd;
        start_test("reg_ops");
        for (int k = 1; k <= 5; k++) begin
            r = lcg_next();
            step_cycle(1'b1, enc_u(OPC_LUI, r[31:12], 5'(k)), 1'b0);
            step_cycle(1'b1, enc_i(r[11:0], 5'(k), 5'(k)), 1'b0);
        end
        repeat (20) begin
            sel = lcg_next() % 32'd5;
            rd  = pick_reg();
            case (sel)
                0: r = enc_rs(F7_BASE, pick_reg(), pick_reg(), F3_ADD, rd, OPC_OP);
                1: r = enc_rs(F7_SUB, pick_reg(), pick_reg(), F3_ADD, rd, OPC_OP);
                2: r = enc_rs(F7_BASE, pick_reg(), pick_reg(), F3_AND, rd, OPC_OP);
                3: r = enc_rs(F7_BASE, pick_reg(), pick_reg(), F3_OR, rd, OPC_OP);
                default: r = enc_rs(F7_BASE, pick_reg(), pick_reg(), F3_XOR, rd, OPC_OP);
            endcase
            step_cycle(1'b1, r, 1'b0);
        end
        finish_test();
    endtask

    task automatic test_x0();
        start_test("x0");
        step_cycle(1'b1, enc_i(12'd5, 5'd0, 5'd0), 1'b0);
        step_cycle(1'b1, enc_rs(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd2, OPC_OP), 1'b0);
        finish_test();
    endtask

    task automatic test_non_exec();
        start_test("non_exec");
        step_cycle(1'b1, 32'hffff_ffff, 1'b0);
        idle(1);
        step_cycle(1'b1, enc_rs(7'd0, 5'd2, 5'd1, F3_BEQ, 5'd8, OPC_BRANCH), 1'b0);
        step_cycle(1'b1, enc_rs(7'd0, 5'd2, 5'd1, F3_W, 5'd4, OPC_STORE), 1'b0);
        idle(1);
        step_cycle(1'b1, enc_i(12'd1, 5'd0, 5'd5), 1'b0);   // tag must not have moved.
        finish_test();
    endtask

    task automatic test_flush();
        start_test("flush");
        step_cycle(1'b1, enc_i(12'd3, 5'd0, 5'd11), 1'b0);
        step_cycle(1'b1, enc_i(12'd4, 5'd0, 5'd12), 1'b0);
        idle(1);
        step_cycle(1'b1, enc_i(12'd77, 5'd0, 5'd10), 1'b0);  // completes.
        step_cycle(1'b1, enc_i(12'd88, 5'd0, 5'd11), 1'b0);  // killed in execute.
        step_cycle(1'b1, enc_i(12'd99, 5'd0, 5'd12), 1'b1);  // absent.
        idle(1);
        step_cycle(1'b1, enc_rs(F7_BASE, 5'd12, 5'd11, F3_ADD, 5'd13, OPC_OP), 1'b0);
        step_cycle(1'b1, enc_rs(F7_BASE, 5'd0, 5'd10, F3_ADD, 5'd14, OPC_OP), 1'b0);
        finish_test();
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        pc_i          = '0;
        flush_i       = 1'b0;
        seed          = 32'h988b_acd7;
        pc_ctr        = 32'h0000_1000;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int i = 0; i < 32; i++) mregs[i] = 32'h0;
        m_tag   = 4'd0;
        {p_v, p_flush, d_v, d_ill, w_v} = '0;
        {p_instr, p_pc, d_instr, d_pc}  = '0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        test_reset_state();
        test_imm_forms();
        test_reg_ops();
        test_x0();
        test_non_exec();
        test_flush();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((RUN_CYCLES + 50) * 10);
        $display("watchdog: the run did not finish within %0d cycles", RUN_CYCLES + 50);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: decode_exec_top.sv
module decode_exec_top import core_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              flush_i,
    output logic              illegal_o,
    output logic              wb_valid_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic [TAG_W-1:0]  wb_tag_o
);

    uop_t              dec_uop;
    uop_t              dec_uop_q;
    uop_t              exe_uop;
    wb_t               exe_wb;
    wb_t               wb_q;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;

    // ------------------------------------------------------------------------
    // decode stage
    // ------------------------------------------------------------------------
    uop_decoder u_dec (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .flush_i       (flush_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .uop_o         (dec_uop)
    );

    stage_reg #(.payload_t(uop_t)) u_dec_q (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (flush_i),
        .d_i     (dec_uop),
        .q_o     (dec_uop_q)
    );

    // ------------------------------------------------------------------------
    // execute and writeback
    // ------------------------------------------------------------------------
    // flush also kills the micro-op sitting in execute.
    always_comb begin
        exe_uop       = dec_uop_q;
        exe_uop.valid = dec_uop_q.valid && !flush_i;
    end

    alu_execute u_exe (
        .uop_i      (exe_uop),
        .wb_fwd_i   (wb_q),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_o       (exe_wb)
    );

    stage_reg #(.payload_t(wb_t)) u_wb_q (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (1'b0),
        .d_i     (exe_wb),
        .q_o     (wb_q)
    );

    reg_file u_rf (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_q.valid && (wb_q.rd != '0)),
        .wr_addr_i  (wb_q.rd),
        .wr_data_i  (wb_q.data)
    );

    assign illegal_o  = dec_uop_q.illegal;
    assign wb_valid_o = wb_q.valid;
    assign wb_rd_o    = wb_q.rd;
    assign wb_data_o  = wb_q.data;
    assign wb_tag_o   = wb_q.tag;

endmodule

// File: alu_execute.sv
module alu_execute import core_pkg::*; (
    input  uop_t              uop_i,
    input  wb_t               wb_fwd_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output wb_t               wb_o
);

    logic            fwd_ok;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    assign rs1_addr_o = uop_i.rs1;
    assign rs2_addr_o = uop_i.rs2;

    // ------------------------------------------------------------------------
    // forwarding from the writeback register
    // ------------------------------------------------------------------------
    // the result in wb covers the cycle before it lands in the file.
    assign fwd_ok = wb_fwd_i.valid && (wb_fwd_i.rd != '0);

    assign rs1_val = (fwd_ok && (wb_fwd_i.rd == uop_i.rs1)) ? wb_fwd_i.data : rs1_data_i;
    assign rs2_val = (fwd_ok && (wb_fwd_i.rd == uop_i.rs2)) ? wb_fwd_i.data : rs2_data_i;

    // ------------------------------------------------------------------------
    // operands and alu
    // ------------------------------------------------------------------------
    always_comb begin
        case (uop_i.opa_sel)
            OPA_RS1:  op_a = rs1_val;
            OPA_PC:   op_a = uop_i.pc;
            OPA_ZERO: op_a = '0;           // lui.
            default:  op_a = '0;
        endcase
    end

    assign op_b = (uop_i.opb_sel == OPB_IMM) ? uop_i.imm : rs2_val;

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: result = '0;
        endcase
    end

    // writeback record, rd 0 still reported.
    always_comb begin
        wb_o.valid = uop_i.valid && uop_i.rd_we;
        wb_o.rd    = uop_i.rd;
        wb_o.data  = result;
        wb_o.tag   = uop_i.tag;
    end

endmodule

// File: reg_file.sv
module reg_file import core_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [REG_AW-1:0] rs1_addr_i,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] wr_addr_i,
    input  logic [XLEN-1:0]   wr_data_i
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin   // x0 never written.
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // combinational read, x0 reads as zero.
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     clear_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // one payload per cycle, zeroed on reset or clear.
    always_ff @(posedge clk_i) begin
        if (!rstn_i || clear_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// File: uop_decoder.sv
module uop_decoder import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            instr_valid_i,
    input  logic            flush_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    output uop_t            uop_o
);

    logic             decode_en;
    logic             alu_hit;
    logic             other_hit;
    logic [TAG_W-1:0] tag_q;
    logic             issued_q;

    logic is_lui, is_auipc, is_jal, is_jalr;
    logic is_beq, is_bne, is_blt, is_lw, is_sw;
    logic is_addi, is_add, is_sub, is_and, is_or, is_xor;

    function automatic logic [31:0] pat(
        input logic [6:0] f7,
        input logic [2:0] f3,
        input logic [6:0] opc
    );
        return {f7, 10'b0, f3, 5'b0, opc};
    endfunction

    function automatic logic hit(
        input logic [31:0] word,
        input logic [31:0] mask,
        input logic [31:0] match
    );
        return (word & mask) == match;
    endfunction

    // ------------------------------------------------------------------------
    // pattern match
    // ------------------------------------------------------------------------
    assign is_lui   = hit(instr_i, MASK_U, pat(F7_BASE, 3'b000, OPC_LUI));
    assign is_auipc = hit(instr_i, MASK_U, pat(F7_BASE, 3'b000, OPC_AUIPC));
    assign is_jal   = hit(instr_i, MASK_U, pat(F7_BASE, 3'b000, OPC_JAL));
    assign is_jalr  = hit(instr_i, MASK_I, pat(F7_BASE, F3_ADD, OPC_JALR));
    assign is_beq   = hit(instr_i, MASK_I, pat(F7_BASE, F3_BEQ, OPC_BRANCH));
    assign is_bne   = hit(instr_i, MASK_I, pat(F7_BASE, F3_BNE, OPC_BRANCH));
    assign is_blt   = hit(instr_i, MASK_I, pat(F7_BASE, F3_BLT, OPC_BRANCH));
    assign is_lw    = hit(instr_i, MASK_I, pat(F7_BASE, F3_W, OPC_LOAD));
    assign is_sw    = hit(instr_i, MASK_I, pat(F7_BASE, F3_W, OPC_STORE));
    assign is_addi  = hit(instr_i, MASK_I, pat(F7_BASE, F3_ADD, OPC_OP_IMM));
    assign is_add   = hit(instr_i, MASK_R, pat(F7_BASE, F3_ADD, OPC_OP));
    assign is_sub   = hit(instr_i, MASK_R, pat(F7_SUB, F3_ADD, OPC_OP));
    assign is_and   = hit(instr_i, MASK_R, pat(F7_BASE, F3_AND, OPC_OP));
    assign is_or    = hit(instr_i, MASK_R, pat(F7_BASE, F3_OR, OPC_OP));
    assign is_xor   = hit(instr_i, MASK_R, pat(F7_BASE, F3_XOR, OPC_OP));

    assign alu_hit   = is_lui | is_auipc | is_addi | is_add | is_sub
                     | is_and | is_or | is_xor;
    // recognised, but no micro-op.
    assign other_hit = is_jal | is_jalr | is_beq | is_bne | is_blt | is_lw | is_sw;

    assign decode_en = instr_valid_i && !flush_i;   // flushed word is absent.

    // ------------------------------------------------------------------------
    // micro-op build
    // ------------------------------------------------------------------------
    always_comb begin
        uop_o         = '0;
        uop_o.valid   = decode_en && alu_hit;
        uop_o.illegal = decode_en && !(alu_hit || other_hit);
        uop_o.tag     = tag_q;
        uop_o.pc      = pc_i;
        uop_o.rs1     = instr_i[19:15];
        uop_o.rs2     = instr_i[24:20];
        uop_o.rd      = instr_i[11:7];
        uop_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        uop_o.alu_op  = ALU_ADD;
        uop_o.opa_sel = OPA_RS1;
        uop_o.opb_sel = OPB_IMM;
        uop_o.rd_we   = alu_hit;

        if (is_lui || is_auipc) begin
            uop_o.imm     = {instr_i[31:12], 12'b0};
            uop_o.opa_sel = is_lui ? OPA_ZERO : OPA_PC;
        end

        if (is_add || is_sub || is_and || is_or || is_xor) begin
            uop_o.opb_sel = OPB_RS2;
            if (is_sub) begin
                uop_o.alu_op = ALU_SUB;
            end else if (is_and) begin
                uop_o.alu_op = ALU_AND;
            end else if (is_or) begin
                uop_o.alu_op = ALU_OR;
            end else if (is_xor) begin
                uop_o.alu_op = ALU_XOR;
            end
        end
    end

    // tag counter. a flush also kills the micro-op issued one edge ago,
    // so its tag is handed back.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tag_q    <= '0;
            issued_q <= 1'b0;
        end else begin
            issued_q <= uop_o.valid;
            if (uop_o.valid) begin
                tag_q <= tag_q + 1'b1;   // wraps mod 16.
            end else if (flush_i && issued_q) begin
                tag_q <= tag_q - 1'b1;
            end
        end
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int TAG_W  = 4;

    // ------------------------------------------------------------------------
    // rv32i encoding fields
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD = 3'b000;   // also jalr.
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_W   = 3'b010;   // word load and store.

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // which bits take part in a match, per format.
    localparam logic [31:0] MASK_U = 32'h0000_007f;
    localparam logic [31:0] MASK_I = 32'h0000_707f;
    localparam logic [31:0] MASK_R = 32'hfe00_707f;

    // ------------------------------------------------------------------------
    // micro-op encodings
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_e;

    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;      // sign-extended or upper.
        alu_op_e           alu_op;
        opa_sel_e          opa_sel;
        opb_sel_e          opb_sel;
        logic              rd_we;
    } uop_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic [TAG_W-1:0]  tag;
    } wb_t;

endpackage
